// File: design/fetch_pkg.sv
/*
 * Shared definitions of the fetch front end
 * Data width, reset PC and instruction memory geometry
 */

package fetch_pkg;

  // --------------------------------------------------
  // Datapath
  // --------------------------------------------------

  // Width of a PC and of an instruction word
  localparam int xlen = 32;

  // First fetch address after reset
  localparam logic [xlen-1:0] reset_pc = '0;

  // --------------------------------------------------
  // Instruction memory
  // --------------------------------------------------

  // Depth in words, addresses wrap modulo this
  localparam int mem_words = 16;

  // Word index width
  localparam int addr_bits = $clog2(mem_words);

  // Byte offset inside a word
  // 32-bit words, so the low two address bits are dropped
  localparam int byte_bits = 2;

  // PC step between sequential fetches
  localparam logic [xlen-1:0] pc_step = xlen'(4);

  // Contents of the instruction memory
  localparam string mem_file = "design/inst_mem.hex";

endpackage

// File: design/fetch_top.sv
/*
 * Front end top level
 * Fetch unit and instruction memory joined by the memory channel
 */

`timescale 1ns/1ps

module fetch_top #(
  parameter int p_seq_num_bits  = 3,
  parameter int p_opaq_bits     = 4,
  parameter int p_max_in_flight = 4,
  parameter int p_mem_latency   = 2
) (
  input  logic                       clk,
  input  logic                       reset,
  // Decode channel
  output logic                       d_val,
  input  logic                       d_rdy,
  output logic [fetch_pkg::xlen-1:0] d_inst,
  output logic [fetch_pkg::xlen-1:0] d_pc,
  output logic [p_seq_num_bits-1:0]  d_seq_num,
  // Commit notification
  input  logic                       commit_val,
  input  logic [p_seq_num_bits-1:0]  commit_seq_num,
  // Squash notification
  input  logic                       squash_val,
  input  logic [p_seq_num_bits-1:0]  squash_seq_num,
  input  logic [fetch_pkg::xlen-1:0] squash_target
);

  // Memory channel
  imem_if #(
    .p_opaq_bits (p_opaq_bits)
  ) mem_bus ();

  fetch_unit #(
    .p_seq_num_bits  (p_seq_num_bits),
    .p_opaq_bits     (p_opaq_bits),
    .p_max_in_flight (p_max_in_flight)
  ) fetch0 (
    .clk            (clk),
    .reset          (reset),
    .mem            (mem_bus.fetcher),
    .d_val          (d_val),
    .d_rdy          (d_rdy),
    .d_inst         (d_inst),
    .d_pc           (d_pc),
    .d_seq_num      (d_seq_num),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .squash_val     (squash_val),
    .squash_seq_num (squash_seq_num),
    .squash_target  (squash_target)
  );

  inst_mem #(
    .p_mem_latency (p_mem_latency),
    .p_opaq_bits   (p_opaq_bits)
  ) imem0 (
    .clk   (clk),
    .reset (reset),
    .bus   (mem_bus.memory)
  );

endmodule

// File: design/fetch_unit.sv
/*
 * Fetch unit with PC generation, in-flight limit, PC queue and response buffer,
 * epoch filtering of stale responses and the decode val/rdy output
 */

`timescale 1ns/1ps

module fetch_unit #(
  parameter int p_seq_num_bits  = 3,
  parameter int p_opaq_bits     = 4,
  parameter int p_max_in_flight = 4
) (
  input  logic                      clk,
  input  logic                      reset,
  imem_if.fetcher                   mem,
  output logic                      d_val,
  input  logic                      d_rdy,
  output logic [fetch_pkg::xlen-1:0] d_inst,
  output logic [fetch_pkg::xlen-1:0] d_pc,
  output logic [p_seq_num_bits-1:0] d_seq_num,
  input  logic                      commit_val,
  input  logic [p_seq_num_bits-1:0] commit_seq_num,
  input  logic                      squash_val,
  input  logic [p_seq_num_bits-1:0] squash_seq_num,
  input  logic [fetch_pkg::xlen-1:0] squash_target
);
  import fetch_pkg::*;

  localparam int idx_bits = (p_max_in_flight > 1) ? $clog2(p_max_in_flight) : 1;
  localparam int cnt_bits = $clog2(p_max_in_flight + 1);

  // Next slot in the ring
  // Depth need not be a power of two
  function automatic logic [idx_bits-1:0] ring_inc(input logic [idx_bits-1:0] p);
    if (p == idx_bits'(p_max_in_flight - 1))
      return '0;
    return p + idx_bits'(1);
  endfunction

  // --------------------------------------------------
  // State
  // --------------------------------------------------

  logic [xlen-1:0]        pc_q;
  logic [p_opaq_bits-1:0] epoch_q;
  logic [cnt_bits-1:0]    in_flight_q;
  logic [cnt_bits-1:0]    buf_count_q;

  // One ring holds both queues
  // PC written at request, word written at response
  logic [xlen-1:0] pc_ring   [p_max_in_flight];
  logic [xlen-1:0] inst_ring [p_max_in_flight];

  // Request tail, response pointer, delivery head
  logic [idx_bits-1:0] tail_q;
  logic [idx_bits-1:0] resp_ptr_q;
  logic [idx_bits-1:0] head_q;

  logic req_fire;
  logic resp_keep;
  logic resp_drop;
  logic deliver;
  logic seq_avail;

  // --------------------------------------------------
  // Handshakes
  // --------------------------------------------------

  // No new request while squashing or at the in-flight limit
  assign req_fire = !squash_val && (in_flight_q < cnt_bits'(p_max_in_flight));

  // Squash cycle drops everything that arrives
  assign resp_keep = mem.resp_val && !squash_val && (mem.resp_opaq == epoch_q);
  assign resp_drop = mem.resp_val && !resp_keep;

  assign mem.req_val  = req_fire;
  assign mem.req_addr = pc_q;
  assign mem.req_opaq = epoch_q;

  // Decode output from the ring head
  assign d_val   = (buf_count_q != '0) && seq_avail && !squash_val;
  assign d_inst  = inst_ring[head_q];
  assign d_pc    = pc_ring[head_q];
  assign deliver = d_val && d_rdy;

  seq_num_alloc #(
    .p_seq_num_bits (p_seq_num_bits)
  ) seq_alloc (
    .clk            (clk),
    .reset          (reset),
    .alloc          (deliver),
    .avail          (seq_avail),
    .seq_num        (d_seq_num),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .squash_val     (squash_val),
    .squash_seq_num (squash_seq_num)
  );

  // --------------------------------------------------
  // Control
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q        <= reset_pc;
      epoch_q     <= '0;
      in_flight_q <= '0;
      buf_count_q <= '0;
      tail_q      <= '0;
      resp_ptr_q  <= '0;
      head_q      <= '0;
    end else begin
      // Responses stay in order and stale ones only advance the pointer
      if (mem.resp_val)
        resp_ptr_q <= ring_inc(resp_ptr_q);

      if (squash_val) begin
        pc_q        <= squash_target;
        epoch_q     <= epoch_q + p_opaq_bits'(1);
        // Buffered words are gone while stale requests count until they return
        in_flight_q <= in_flight_q - buf_count_q - cnt_bits'(mem.resp_val);
        buf_count_q <= '0;
        head_q      <= tail_q;
      end else begin
        if (req_fire) begin
          pc_q   <= pc_q + pc_step;
          tail_q <= ring_inc(tail_q);
        end
        if (deliver)
          head_q <= ring_inc(head_q);
        in_flight_q <= in_flight_q + cnt_bits'(req_fire) - cnt_bits'(deliver)
                       - cnt_bits'(resp_drop);
        buf_count_q <= buf_count_q + cnt_bits'(resp_keep) - cnt_bits'(deliver);
      end
    end
  end

  // Ring payload
  always_ff @(posedge clk) begin
    if (req_fire)
      pc_ring[tail_q] <= pc_q;
    if (resp_keep)
      inst_ring[resp_ptr_q] <= mem.resp_data;
  end

endmodule

// File: design/imem_if.sv
/*
 * Request and response channel between fetch and instruction memory
 */

`timescale 1ns/1ps

interface imem_if #(
  parameter int p_opaq_bits = 4
);
  import fetch_pkg::*;

  // Request, taken whenever req_val is high
  logic                   req_val;
  logic [xlen-1:0]        req_addr;
  logic [p_opaq_bits-1:0] req_opaq;

  // Response, fixed latency, in request order
  logic                   resp_val;
  logic [xlen-1:0]        resp_data;
  logic [p_opaq_bits-1:0] resp_opaq;

  modport fetcher (
    output req_val, req_addr, req_opaq,
    input  resp_val, resp_data, resp_opaq
  );

  modport memory (
    input  req_val, req_addr, req_opaq,
    output resp_val, resp_data, resp_opaq
  );

endinterface

// File: design/inst_mem.hex
// Instruction memory image, one 32-bit word per line in hex
// Line n holds word index n, fetched at PC 4*n modulo the depth
00100093
00200113
002081b3
40118233
0041a2a3
0051a303
00628393
00739413
0083f4b3
00946533
00a4e5b3
00b54633
00c5a6b3
00d62733
fe0008e3
0000006f

// File: design/inst_mem.sv
/*
 * Read-only instruction memory with a fixed-latency read pipeline
 */

`timescale 1ns/1ps

module inst_mem #(
  parameter int p_mem_latency = 2,
  parameter int p_opaq_bits   = 4
) (
  input  logic   clk,
  input  logic   reset,
  imem_if.memory bus
);
  import fetch_pkg::*;

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  logic [xlen-1:0] rom [mem_words];

  initial begin
    $readmemh(mem_file, rom);
  end

  // Word index, upper address bits wrap around the depth
  logic [addr_bits-1:0] word_idx;

  assign word_idx = bus.req_addr[addr_bits+byte_bits-1:byte_bits];

  // --------------------------------------------------
  // Read pipeline
  // --------------------------------------------------

  logic                   val_q  [p_mem_latency];
  logic [xlen-1:0]        data_q [p_mem_latency];
  logic [p_opaq_bits-1:0] opaq_q [p_mem_latency];

  // Valid bits
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < p_mem_latency; i++)
        val_q[i] <= 1'b0;
    end else begin
      val_q[0] <= bus.req_val;
      for (int i = 1; i < p_mem_latency; i++)
        val_q[i] <= val_q[i-1];
    end
  end

  // Payload, word and tag travel with the valid bit
  always_ff @(posedge clk) begin
    data_q[0] <= rom[word_idx];
    opaq_q[0] <= bus.req_opaq;
    for (int i = 1; i < p_mem_latency; i++) begin
      data_q[i] <= data_q[i-1];
      opaq_q[i] <= opaq_q[i-1];
    end
  end

  assign bus.resp_val  = val_q[p_mem_latency-1];
  assign bus.resp_data = data_q[p_mem_latency-1];
  assign bus.resp_opaq = opaq_q[p_mem_latency-1];

endmodule

// File: design/seq_num_alloc.sv
/*
 * In-order sequence number allocator
 * Numbers are handed out at delivery, released by commit, rolled back by squash
 */

`timescale 1ns/1ps

module seq_num_alloc #(
  parameter int p_seq_num_bits = 3
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      alloc,
  output logic                      avail,
  output logic [p_seq_num_bits-1:0] seq_num,
  input  logic                      commit_val,
  input  logic [p_seq_num_bits-1:0] commit_seq_num,
  input  logic                      squash_val,
  input  logic [p_seq_num_bits-1:0] squash_seq_num
);

  // Live count needs one extra bit to reach the full range
  localparam int cnt_w = p_seq_num_bits + 1;
  localparam logic [cnt_w-1:0] num_seq = cnt_w'(2 ** p_seq_num_bits);

  logic [p_seq_num_bits-1:0] next_q;
  logic [p_seq_num_bits-1:0] oldest_q;
  logic [cnt_w-1:0]          live_q;

  logic                      commit_fire;
  logic [p_seq_num_bits-1:0] squash_dist;

  // Commit only counts when it names the oldest live number
  assign commit_fire = commit_val && (commit_seq_num == oldest_q) && (live_q != '0);

  // Distance from oldest to the squashing instruction, which stays live
  assign squash_dist = squash_seq_num - oldest_q;

  assign avail   = (live_q < num_seq);
  assign seq_num = next_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      next_q   <= '0;
      oldest_q <= '0;
      live_q   <= '0;
    end else begin
      // Oldest only ever moves by commit
      if (commit_fire)
        oldest_q <= oldest_q + p_seq_num_bits'(1);

      if (squash_val) begin
        // Younger numbers are killed
        next_q <= squash_seq_num + p_seq_num_bits'(1);
        live_q <= cnt_w'(squash_dist) + cnt_w'(1) - cnt_w'(commit_fire);
      end else begin
        next_q <= next_q + p_seq_num_bits'(alloc);
        live_q <= live_q + cnt_w'(alloc) - cnt_w'(commit_fire);
      end
    end
  end

endmodule

// File: project.f
+incdir+verif
design/fetch_pkg.sv
design/imem_if.sv
design/seq_num_alloc.sv
design/inst_mem.sv
design/fetch_unit.sv
design/fetch_top.sv
verif/fetch_tb.sv

// File: run.sh
#!/bin/sh
# Compile the fetch front end with its testbench and run it
# The simulator exit status is the result of the regression
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f project.f \
  --top-module fetch_tb \
  -o fetch_sim

./obj_dir/fetch_sim

// File: verif/fetch_tests.svh
/*
 * Directed tests of the fetch front end
 * Sequential stream, back-pressure, sequence limit, squash, wrap-around
 */

// Decode always ready, one commit per delivery
task automatic test_sequential(input int count);
  apply_reset();
  for (int i = 0; i < count; i++) begin
    receive(1'b0);
    expect_next();
    commit_oldest();
  end
endtask

// Random ready, stream must match the plain one
task automatic test_back_pressure(input int count);
  apply_reset();
  for (int i = 0; i < count; i++) begin
    receive(1'b1);
    expect_next();
    commit_oldest();
  end
endtask

// No commits, all numbers end up live
task automatic test_seq_limit();
  apply_reset();
  for (int i = 0; i < num_seq; i++) begin
    receive(1'b0);
    expect_next();
  end
  expect_quiet(50);

  // Releasing number 0 lets exactly one more through
  commit_oldest();
  receive(1'b0);
  check_eq("d_seq_num after commit", 32'(got_seq), 32'd0);
  expect_next();
  expect_quiet(20);
endtask

task automatic test_squash();
  apply_reset();

  // Three delivered and still live
  for (int i = 0; i < 3; i++) begin
    receive(1'b0);
    expect_next();
  end
  // Buffer fills behind the stalled decode
  repeat (6) next_cycle();

  // Kill everything younger than number 1
  squash(seq_bits'(1), 32'h24);
  for (int i = 0; i < 5; i++) begin
    receive(1'b0);
    expect_next();
    commit_oldest();
  end

  // Squash at the youngest, responses still in flight
  // Target is the last word, so the stream wraps to word 0
  squash(exp_seq - seq_bits'(1), 32'h3c);
  for (int i = 0; i < 6; i++) begin
    receive(1'b0);
    expect_next();
    commit_oldest();
  end
endtask

// Sequence numbers cycle modulo 8, words modulo 16
task automatic test_wrap(input int count);
  logic [addr_bits-1:0] idx;
  apply_reset();
  for (int i = 0; i < count; i++) begin
    receive(1'b0);
    idx = addr_bits'(i % mem_words);
    check_eq("d_pc", got_pc, xlen'(4 * i));
    check_eq("d_seq_num", 32'(got_seq), 32'(i % num_seq));
    check_eq("d_inst", got_inst, ref_mem[idx]);
    commit_oldest();
  end
endtask

// File: verif/fetch_tb.sv
/*
 * Testbench of the fetch front end
 * Clock, reset, DUT, check task, stimulus helpers and test sequence
 */

`timescale 1ns/1ps

module fetch_tb;
  import fetch_pkg::*;

  localparam int    seq_bits = 3;
  localparam int    num_seq  = 2 ** seq_bits;
  localparam int    timeout  = 200;
  localparam string hex_file = "design/inst_mem.hex";

  logic                clk;
  logic                reset;
  logic                d_val;
  logic                d_rdy;
  logic [xlen-1:0]     d_inst;
  logic [xlen-1:0]     d_pc;
  logic [seq_bits-1:0] d_seq_num;
  logic                commit_val;
  logic [seq_bits-1:0] commit_seq_num;
  logic                squash_val;
  logic [seq_bits-1:0] squash_seq_num;
  logic [xlen-1:0]     squash_target;

  // Reference copy of the program
  logic [xlen-1:0] ref_mem [mem_words];
  int seed;

  // Last instruction taken from decode
  logic [xlen-1:0]     got_pc;
  logic [xlen-1:0]     got_inst;
  logic [seq_bits-1:0] got_seq;

  // Expected stream and oldest live number
  logic [xlen-1:0]     exp_pc;
  logic [seq_bits-1:0] exp_seq;
  logic [seq_bits-1:0] oldest;

  initial clk = 1'b0;
  always #50 clk = ~clk;

  fetch_top #(
    .p_seq_num_bits (seq_bits)
  ) dut0 (
    .clk            (clk),
    .reset          (reset),
    .d_val          (d_val),
    .d_rdy          (d_rdy),
    .d_inst         (d_inst),
    .d_pc           (d_pc),
    .d_seq_num      (d_seq_num),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .squash_val     (squash_val),
    .squash_seq_num (squash_seq_num),
    .squash_target  (squash_target)
  );

  // --------------------------------------------------
  // Checking
  // --------------------------------------------------

  task automatic stop_run();
    $display("Regression failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  // Word for a PC, index wraps with the memory depth
  function automatic logic [xlen-1:0] word_at(input logic [xlen-1:0] pc);
    logic [addr_bits-1:0] idx;
    idx = addr_bits'((pc >> 2) % mem_words);
    return ref_mem[idx];
  endfunction

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // All inputs idle, reset for two cycles
  task automatic apply_reset();
    reset          = 1'b1;
    d_rdy          = 1'b0;
    commit_val     = 1'b0;
    commit_seq_num = '0;
    squash_val     = 1'b0;
    squash_seq_num = '0;
    squash_target  = '0;
    repeat (2) next_cycle();
    reset   = 1'b0;
    exp_pc  = reset_pc;
    exp_seq = '0;
    oldest  = '0;
  endtask

  // Wait for one transfer on the decode channel
  // Random ready when asked, stalled data must hold
  task automatic receive(input bit rand_rdy);
    int              cycles;
    int              rnd;
    logic            done;
    logic            stalled;
    logic [xlen-1:0] held_pc;
    logic [xlen-1:0] held_inst;
    cycles    = 0;
    done      = 1'b0;
    stalled   = 1'b0;
    held_pc   = '0;
    held_inst = '0;
    while (!done) begin
      if (rand_rdy) begin
        rnd   = $random(seed);
        d_rdy = rnd[0];
      end else begin
        d_rdy = 1'b1;
      end
      @(negedge clk);
      if (stalled) begin
        check_eq("d_val held", 32'(d_val), 32'd1);
        check_eq("d_pc held", d_pc, held_pc);
        check_eq("d_inst held", d_inst, held_inst);
      end
      if (d_val && d_rdy) begin
        done = 1'b1;
      end else begin
        stalled   = d_val;
        held_pc   = d_pc;
        held_inst = d_inst;
        cycles++;
        if (cycles >= timeout) begin
          $display("Timeout: no instruction on the decode channel in %0d cycles", timeout);
          stop_run();
        end
        next_cycle();
      end
    end
    got_pc   = d_pc;
    got_inst = d_inst;
    got_seq  = d_seq_num;
    next_cycle();
    d_rdy = 1'b0;
  endtask

  // Compare with the expected stream, then step it
  task automatic expect_next();
    check_eq("d_pc", got_pc, exp_pc);
    check_eq("d_seq_num", 32'(got_seq), 32'(exp_seq));
    check_eq("d_inst", got_inst, word_at(exp_pc));
    exp_pc  = exp_pc + 32'd4;
    exp_seq = exp_seq + seq_bits'(1);
  endtask

  task automatic commit_oldest();
    commit_val     = 1'b1;
    commit_seq_num = oldest;
    next_cycle();
    commit_val = 1'b0;
    oldest     = oldest + seq_bits'(1);
  endtask

  // One-cycle squash, decode must see nothing in that cycle
  task automatic squash(input logic [seq_bits-1:0] s, input logic [xlen-1:0] target);
    squash_val     = 1'b1;
    squash_seq_num = s;
    squash_target  = target;
    @(negedge clk);
    check_eq("d_val in squash cycle", 32'(d_val), 32'd0);
    next_cycle();
    squash_val = 1'b0;
    exp_pc     = target;
    exp_seq    = s + seq_bits'(1);
  endtask

  // Decode ready, yet nothing may arrive
  task automatic expect_quiet(input int cycles);
    d_rdy = 1'b1;
    repeat (cycles) begin
      @(negedge clk);
      check_eq("d_val", 32'(d_val), 32'd0);
      next_cycle();
    end
    d_rdy = 1'b0;
  endtask

  `include "fetch_tests.svh"

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    seed = 91;
    $readmemh(hex_file, ref_mem);
    test_sequential(12);
    test_back_pressure(24);
    test_seq_limit();
    test_squash();
    test_wrap(40);
    $display("Regression passed");
    $finish;
  end

endmodule
